/* sim.f */
+incdir+.
wc_pkg.sv
packet_if.sv
flit_packer.sv
packet_fifo.sv
flit_unpacker.sv
width_converter.sv
tb_clock.sv
width_converter_sva.sv
width_converter_tb.sv

/* Makefile */
.PHONY: sim clean

sim:
	verilator --binary --timing --assert --top-module width_converter_tb -f sim.f -Mdir obj_dir
	./obj_dir/Vwidth_converter_tb | tee sim.log
	grep -q "RESULT: PASS" sim.log

clean:
	rm -rf obj_dir sim.log

/* width_converter_tb.sv */
// ##################################################
// Random push and pop traffic from a fixed seed, checked against a flit model.
// ##################################################
`timescale 1ns/10ps
`include "wc_config.svh"

module width_converter_tb import wc_pkg::*; ();

  localparam int          RESET_CYCLES   = 16;
  localparam int          TIMEOUT_CYCLES = 200 * `WC_PUSH_FLITS * 8 + RESET_CYCLES;
  localparam int          STALL_FLITS    = `WC_PUSH_FLITS * (`WC_FIFO_DEPTH + 2);
  localparam int          STALL_WINDOW   = 40;
  localparam int unsigned PUSH_PCT       = 75;

  logic       clk;
  logic       rst = 1'b1;
  logic       push_valid = 1'b0;
  logic       push_ready;
  push_flit_t push_data = '0;
  sideband_t  push_sideband = '0;
  logic       pop_valid;
  logic       pop_ready = 1'b0;
  pop_flit_t  pop_data;
  sideband_t  pop_sideband;

  int unsigned pop_pct = 100; // Duty cycle of pop_ready in percent.
  int          push_budget = 0; // Push flits the driver may offer so far.

  int          push_offered = 0;
  int          push_count = 0;
  int          pop_count = 0;
  int          pop_errors = 0;
  int          sideband_errors = 0;
  int          main_errors = 0;
  int          cycle_count = 0;
  int          tests_run = 0;
  int          tests_failed = 0;
  push_flit_t  flit_buf [`WC_PUSH_FLITS];
  sideband_t   first_sideband;
  pop_flit_t   exp_data_q [$];
  sideband_t   exp_sideband_q [$];

  tb_clock tb_clock_inst (.clk(clk));

  width_converter width_converter_inst (
    .clk           (clk),
    .rst           (rst),
    .push_valid    (push_valid),
    .push_ready    (push_ready),
    .push_data     (push_data),
    .push_sideband (push_sideband),
    .pop_valid     (pop_valid),
    .pop_ready     (pop_ready),
    .pop_data      (pop_data),
    .pop_sideband  (pop_sideband)
  );

  // ##################################################
  // Model and checks
  // ##################################################

  // Two neighbouring push flits form one pop flit with flit 0 in the low half.
  task automatic record_push(input push_flit_t data, input sideband_t sideband);
    int slot;
    int i;
    slot = push_count % `WC_PUSH_FLITS;
    flit_buf[slot] = data;
    if (slot == 0) begin
      first_sideband = sideband;
    end
    if (slot == `WC_PUSH_FLITS - 1) begin
      for (i = 0; i < `WC_POP_FLITS; i++) begin
        exp_data_q.push_back({flit_buf[2 * i + 1], flit_buf[2 * i]});
        exp_sideband_q.push_back(first_sideband);
      end
    end
    push_count++;
  endtask

  task automatic check_pop(input pop_flit_t data, input sideband_t sideband);
    pop_flit_t exp_data;
    sideband_t exp_sideband;
    if (exp_data_q.size() == 0) begin
      $display("Unexpected pop flit at %0t ns while the model expects nothing", $time);
      pop_errors++;
    end else begin
      exp_data     = exp_data_q.pop_front();
      exp_sideband = exp_sideband_q.pop_front();
      if (data !== exp_data) begin
        $display("Fail %0t ns: pop flit %0d data %h, expected %h",
                 $time, pop_count, data, exp_data);
        pop_errors++;
      end
      if (sideband !== exp_sideband) begin
        $display("Fail %0t ns: pop flit %0d sideband %h, expected %h",
                 $time, pop_count, sideband, exp_sideband);
        sideband_errors++;
      end
    end
    pop_count++;
  endtask

  task automatic report_test(input string name, input int errors);
    tests_run++;
    if (errors == 0) begin
      $display("Test %0d %s: ok", tests_run, name);
    end else begin
      tests_failed++;
      $display("Test %0d %s: %0d errors", tests_run, name, errors);
    end
  endtask

  task automatic wait_for_pops(input int target);
    while (pop_count < target) begin
      @(negedge clk);
    end
  endtask

  // ##################################################
  // Drivers and timeout
  // ##################################################

  always @(posedge clk) begin
    if (rst) begin
      push_valid <= 1'b0;
    end else begin
      if (push_valid && push_ready) begin
        record_push(push_data, push_sideband);
      end
      // An offered flit holds until it is taken.
      if (!push_valid || push_ready) begin
        if (push_offered < push_budget && $urandom_range(99) < PUSH_PCT) begin
          push_valid    <= 1'b1;
          push_data     <= push_flit_t'($urandom());
          push_sideband <= sideband_t'($urandom_range(15));
          push_offered  <= push_offered + 1;
        end else begin
          push_valid <= 1'b0;
        end
      end
    end
  end

  always @(posedge clk) begin
    if (rst) begin
      pop_ready <= 1'b0;
    end else begin
      if (pop_valid && pop_ready) begin
        check_pop(pop_data, pop_sideband);
      end
      pop_ready <= $urandom_range(99) < pop_pct;
    end
  end

  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= TIMEOUT_CYCLES) begin
      $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("RESULT: FAIL");
      $finish;
    end
  end

  // ##################################################
  // Test sequence
  // ##################################################

  initial begin
    int base_push;
    int base_pop;
    int base_errors;
    int base_sideband;
    void'($urandom(68190));

    repeat (RESET_CYCLES) @(posedge clk);
    rst <= 1'b0;
    @(negedge clk);
    if (push_ready !== 1'b1 || pop_valid !== 1'b0) begin
      $display("Fail %0t ns: after reset push_ready %b pop_valid %b, expected 1 and 0",
               $time, push_ready, pop_valid);
      main_errors++;
    end
    report_test("reset state", main_errors);

    base_pop      = pop_count;
    base_errors   = pop_errors;
    base_sideband = sideband_errors;
    pop_pct       = 100;
    push_budget   = push_budget + 50 * `WC_PUSH_FLITS;
    wait_for_pops(base_pop + 50 * `WC_POP_FLITS);
    report_test("50 packets with pop always ready", pop_errors - base_errors);
    report_test("sideband on every pop flit", sideband_errors - base_sideband);

    base_pop    = pop_count;
    base_errors = pop_errors + sideband_errors + main_errors;
    pop_pct     = 50;
    push_budget = push_budget + 100 * `WC_PUSH_FLITS;
    wait_for_pops(base_pop + 100 * `WC_POP_FLITS);
    @(negedge clk);
    if (exp_data_q.size() != 0 || pop_valid !== 1'b0) begin
      $display("Fail %0t ns: random phase left %0d expected flits, pop_valid %b",
               $time, exp_data_q.size(), pop_valid);
      main_errors++;
    end
    report_test("100 packets with random pop_ready",
                pop_errors + sideband_errors + main_errors - base_errors);

    // Pop side held off until the whole pipeline is full.
    base_push   = push_count;
    base_pop    = pop_count;
    base_errors = pop_errors + sideband_errors + main_errors;
    pop_pct     = 0;
    @(negedge clk);
    push_budget = push_budget + 8 * `WC_PUSH_FLITS;
    while (push_count < base_push + STALL_FLITS) begin
      @(negedge clk);
    end
    repeat (STALL_WINDOW) begin
      @(negedge clk);
      if (push_ready !== 1'b0 || push_count != base_push + STALL_FLITS) begin
        $display("Fail %0t ns: stalled converter took %0d flits with push_ready %b, expected %0d",
                 $time, push_count - base_push, push_ready, STALL_FLITS);
        main_errors++;
      end
    end
    pop_pct = 100;
    wait_for_pops(base_pop + 8 * `WC_POP_FLITS);
    if (exp_data_q.size() != 0) begin
      $display("Drain after the stall left %0d expected flits", exp_data_q.size());
      main_errors++;
    end
    report_test("back-pressure stall and drain",
                pop_errors + sideband_errors + main_errors - base_errors);

    $display("Tests run %0d, failed %0d, errors %0d, pop flits checked %0d",
             tests_run, tests_failed, pop_errors + sideband_errors + main_errors, pop_count);
    if (tests_failed == 0 && pop_errors + sideband_errors + main_errors == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

endmodule

/* width_converter_sva.sv */
// ##################################################
// Handshake and sideband checks on the top-level ports.
// Assumes two pop flits per packet.
// ##################################################
`timescale 1ns/10ps

module width_converter_sva import wc_pkg::*; (
  input logic       clk,
  input logic       rst,
  input logic       push_valid,
  input logic       push_ready,
  input push_flit_t push_data,
  input sideband_t  push_sideband,
  input logic       pop_valid,
  input logic       pop_ready,
  input pop_flit_t  pop_data,
  input sideband_t  pop_sideband
);

  logic      second_flit;
  sideband_t packet_sideband;

  always_ff @(posedge clk) begin
    if (rst) begin
      second_flit <= 1'b0;
    end else if (pop_valid && pop_ready) begin
      second_flit <= !second_flit; // Toggles once per pop flit.
    end
  end

  // Sideband seen on the first pop flit of the packet.
  always_ff @(posedge clk) begin
    if (pop_valid && pop_ready && !second_flit) begin
      packet_sideband <= pop_sideband;
    end
  end

  // ##################################################
  // Properties
  // ##################################################

  pop_hold_a: assert property (@(posedge clk) disable iff (rst)
    pop_valid && !pop_ready |=> pop_valid && $stable(pop_data) && $stable(pop_sideband))
    else $error("pop flit changed or was dropped while pop_ready was low");

  push_hold_a: assert property (@(posedge clk) disable iff (rst)
    push_valid && !push_ready |=> push_valid && $stable(push_data) && $stable(push_sideband))
    else $error("push flit changed or was dropped while push_ready was low");

  reset_state_a: assert property (@(posedge clk)
    $fell(rst) |-> push_ready && !pop_valid)
    else $error("push_ready low or pop_valid high right after reset");

  sideband_a: assert property (@(posedge clk) disable iff (rst)
    pop_valid && second_flit |-> pop_sideband == packet_sideband)
    else $error("second pop flit carries a different sideband than the first");

endmodule

bind width_converter width_converter_sva width_converter_sva_inst (
  .clk           (clk),
  .rst           (rst),
  .push_valid    (push_valid),
  .push_ready    (push_ready),
  .push_data     (push_data),
  .push_sideband (push_sideband),
  .pop_valid     (pop_valid),
  .pop_ready     (pop_ready),
  .pop_data      (pop_data),
  .pop_sideband  (pop_sideband)
);

/* tb_clock.sv */
// ##################################################
// Free-running testbench clock, 100 ns period.
// ##################################################
`timescale 1ns/10ps

module tb_clock (
  output logic clk
);

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk; // Half period of 50 ns.
  end

endmodule

/* width_converter.sv */
// ###############################################
// 32-bit push flits in, 64-bit pop flits out, four push flits per packet.
// ###############################################
`timescale 1ns/10ps

module width_converter import wc_pkg::*; (
  input  logic       clk,
  input  logic       rst,

  // Push side.
  input  logic       push_valid,
  output logic       push_ready,
  input  push_flit_t push_data,
  input  sideband_t  push_sideband,

  // Pop side.
  output logic       pop_valid,
  input  logic       pop_ready,
  output pop_flit_t  pop_data,
  output sideband_t  pop_sideband
);

  packet_if packed_pkt ();
  packet_if buffered ();

  flit_packer flit_packer_inst (
    .clk           (clk),
    .rst           (rst),
    .push_valid    (push_valid),
    .push_ready    (push_ready),
    .push_data     (push_data),
    .push_sideband (push_sideband),
    .packed_pkt    (packed_pkt.source)
  );

  // Whole packets wait here while the pop side is stalled.
  packet_fifo packet_fifo_inst (
    .clk        (clk),
    .rst        (rst),
    .packed_pkt (packed_pkt.sink),
    .buffered   (buffered.source)
  );

  flit_unpacker flit_unpacker_inst (
    .clk          (clk),
    .rst          (rst),
    .buffered     (buffered.sink),
    .pop_valid    (pop_valid),
    .pop_ready    (pop_ready),
    .pop_data     (pop_data),
    .pop_sideband (pop_sideband)
  );

endmodule

/* flit_unpacker.sv */
// ###############################################
// Sends a held packet as two pop flits. The next packet loads with the last flit.
// ###############################################
`timescale 1ns/10ps
`include "wc_config.svh"

module flit_unpacker import wc_pkg::*; (
  input  logic      clk,
  input  logic      rst,
  packet_if.sink    buffered,
  output logic      pop_valid,
  input  logic      pop_ready,
  output pop_flit_t pop_data,
  output sideband_t pop_sideband
);

  pop_idx_t     pop_idx;
  logic         hold_valid;
  logic         last_flit;
  logic         pop_xfer;
  logic         load;
  packet_word_u hold_word;
  sideband_t    hold_sideband;

  assign last_flit = pop_idx == pop_idx_t'(`WC_POP_FLITS - 1);
  assign pop_xfer  = hold_valid && pop_ready;

  // Take a packet when empty, or as the last flit of the current one leaves.
  assign buffered.ready = !hold_valid || (pop_ready && last_flit);
  assign load           = buffered.valid && buffered.ready;

  // ###############################################
  // Flit sequencing
  // ###############################################

  always_ff @(posedge clk) begin
    if (rst) begin
      hold_valid <= 1'b0;
      pop_idx    <= '0;
    end else if (load) begin
      hold_valid <= 1'b1;
      pop_idx    <= '0;
    end else if (pop_xfer) begin
      if (last_flit) begin
        hold_valid <= 1'b0;
        pop_idx    <= '0;
      end else begin
        pop_idx <= pop_idx + 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (load) begin
      hold_word     <= buffered.data;
      hold_sideband <= buffered.sideband;
    end
  end

  // ###############################################
  // Pop outputs
  // ###############################################

  assign pop_valid    = hold_valid;
  assign pop_data     = hold_word.pop_flits[pop_idx]; // Pop view of the union.
  assign pop_sideband = hold_sideband; // Same sideband on every flit of the packet.

endmodule

/* packet_fifo.sv */
// ###############################################
// Circular buffer of whole packets. Ready is combinational from the read side.
// ###############################################
`timescale 1ns/10ps
`include "wc_config.svh"

module packet_fifo import wc_pkg::*; (
  input  logic   clk,
  input  logic   rst,
  packet_if.sink   packed_pkt,
  packet_if.source buffered
);

  packet_word_u mem_data [`WC_FIFO_DEPTH];
  sideband_t    mem_sideband [`WC_FIFO_DEPTH];
  fifo_ptr_t    wr_ptr;
  fifo_ptr_t    rd_ptr;
  fifo_cnt_t    count;
  logic         full;
  logic         empty;
  logic         wr_en;
  logic         rd_en;

  function automatic fifo_ptr_t next_ptr(input fifo_ptr_t ptr);
    if (ptr == fifo_ptr_t'(`WC_FIFO_DEPTH - 1)) begin
      return '0;
    end
    return ptr + 1'b1;
  endfunction

  assign full  = count == fifo_cnt_t'(`WC_FIFO_DEPTH);
  assign empty = count == '0;

  // A full FIFO still takes a write when the head leaves in the same cycle.
  assign packed_pkt.ready = !full || buffered.ready;
  assign wr_en            = packed_pkt.valid && packed_pkt.ready;
  assign rd_en            = buffered.valid && buffered.ready;

  // ###############################################
  // Storage
  // ###############################################

  always_ff @(posedge clk) begin
    if (wr_en) begin
      mem_data[wr_ptr]     <= packed_pkt.data;
      mem_sideband[wr_ptr] <= packed_pkt.sideband;
    end
  end

  // Head entry comes straight from the register array.
  assign buffered.valid    = !empty;
  assign buffered.data     = mem_data[rd_ptr];
  assign buffered.sideband = mem_sideband[rd_ptr];

  // ###############################################
  // Pointers and occupancy
  // ###############################################

  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
    end else begin
      if (wr_en) begin
        wr_ptr <= next_ptr(wr_ptr);
      end
      if (rd_en) begin
        rd_ptr <= next_ptr(rd_ptr);
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      count <= '0;
    end else begin
      case ({wr_en, rd_en})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count; // Both or neither leave the level unchanged.
      endcase
    end
  end

endmodule

/* flit_packer.sv */
// ###############################################
// Packs four push flits into one packet. No push is taken while a packet waits.
// ###############################################
`timescale 1ns/10ps
`include "wc_config.svh"

module flit_packer import wc_pkg::*; (
  input  logic       clk,
  input  logic       rst,
  input  logic       push_valid,
  output logic       push_ready,
  input  push_flit_t push_data,
  input  sideband_t  push_sideband,
  packet_if.source   packed_pkt
);

  push_idx_t    flit_idx;
  logic         last_flit;
  logic         push_xfer;
  logic         pkt_valid;
  packet_word_u pkt_word;
  sideband_t    pkt_sideband;

  // ###############################################
  // Push side
  // ###############################################

  assign push_ready = !pkt_valid; // A finished packet blocks new flits.
  assign push_xfer  = push_valid && push_ready;
  assign last_flit  = flit_idx == push_idx_t'(`WC_PUSH_FLITS - 1);

  always_ff @(posedge clk) begin
    if (rst) begin
      flit_idx <= '0;
    end else if (push_xfer) begin
      if (last_flit) begin
        flit_idx <= '0;
      end else begin
        flit_idx <= flit_idx + 1'b1;
      end
    end
  end

  // Each accepted flit lands in its own slot of the push view.
  always_ff @(posedge clk) begin
    if (push_xfer) begin
      pkt_word.push_flits[flit_idx] <= push_data;
      if (flit_idx == '0) begin
        pkt_sideband <= push_sideband; // Sideband is sampled on the first flit only.
      end
    end
  end

  // ###############################################
  // Packet side
  // ###############################################

  // Valid rises the cycle after the last flit and drops on the handoff.
  always_ff @(posedge clk) begin
    if (rst) begin
      pkt_valid <= 1'b0;
    end else if (push_xfer && last_flit) begin
      pkt_valid <= 1'b1;
    end else if (pkt_valid && packed_pkt.ready) begin
      pkt_valid <= 1'b0;
    end
  end

  assign packed_pkt.valid    = pkt_valid;
  assign packed_pkt.data     = pkt_word;
  assign packed_pkt.sideband = pkt_sideband;

endmodule

/* packet_if.sv */
// ###############################################
// One whole packet with valid/ready. Payload holds while valid waits.
// ###############################################
`timescale 1ns/10ps

interface packet_if import wc_pkg::*; ();

  logic         valid;
  logic         ready;
  packet_word_u data;
  sideband_t    sideband;

  modport source (
    output valid,
    output data,
    output sideband,
    input  ready
  );

  modport sink (
    input  valid,
    input  data,
    input  sideband,
    output ready
  );

endinterface

/* wc_pkg.sv */
// ###############################################
// Packet union and width types. Both union views must have the same width.
// ###############################################
`include "wc_config.svh"

package wc_pkg;

  typedef logic [`WC_PUSH_FLIT_WIDTH-1:0] push_flit_t;
  typedef logic [`WC_POP_FLIT_WIDTH-1:0]  pop_flit_t;
  typedef logic [`WC_SIDEBAND_WIDTH-1:0]  sideband_t;

  // Flit counters and FIFO bookkeeping.
  typedef logic [$clog2(`WC_PUSH_FLITS)-1:0]     push_idx_t;
  typedef logic [$clog2(`WC_POP_FLITS)-1:0]      pop_idx_t;
  typedef logic [$clog2(`WC_FIFO_DEPTH)-1:0]     fifo_ptr_t;
  typedef logic [$clog2(`WC_FIFO_DEPTH + 1)-1:0] fifo_cnt_t;

  // One packet seen as push flits or as pop flits.
  // Flit 0 sits in the low bits of either view.
  typedef union packed {
    push_flit_t [`WC_PUSH_FLITS-1:0] push_flits;
    pop_flit_t  [`WC_POP_FLITS-1:0]  pop_flits;
  } packet_word_u;

endpackage

/* wc_config.svh */
// ###############################################
// Widths must give equal packet sizes on both sides.
// Pop flits are not narrower than push flits. FIFO depth is at least 2.
// ###############################################
`ifndef WC_CONFIG_SVH
`define WC_CONFIG_SVH

// Four 32-bit flits per packet on the push side.
`define WC_PUSH_FLIT_WIDTH 32
`define WC_PUSH_FLITS 4

// Two 64-bit flits per packet on the pop side.
`define WC_POP_FLIT_WIDTH 64
`define WC_POP_FLITS 2

`define WC_SIDEBAND_WIDTH 4
`define WC_FIFO_DEPTH 2 // Whole packets held between packer and unpacker.

`endif
